/* hw/sched_pkg.sv */
`default_nettype none

package sched_pkg;

  localparam int msg_type_width = 4;
  localparam int ctrl_width = 36;
  localparam int desc_width = ctrl_width - msg_type_width;
  // slot number field inside the descriptor
  localparam int slot_lsb = 16;

  typedef enum logic [msg_type_width-1:0] {
    msg_slot_return = 4'd0,
    msg_pkt_done    = 4'd1,
    msg_pkt_to_core = 4'd2,
    msg_slot_load   = 4'd3
  } msg_type_e;

  typedef logic [ctrl_width-1:0] ctrl_word_t;

  typedef struct packed {
    msg_type_e              msg_type;
    logic [desc_width-1:0]  desc;
  } ctrl_msg_t;

  // index of n items, never narrower than one bit
  function automatic int index_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // slot numbers run 0 to n, 0 meaning no slot
  function automatic int slot_width_of(input int n);
    return $clog2(n + 1);
  endfunction

  function automatic int tag_width_of(input int n);
    return (slot_width_of(n) > 5) ? slot_width_of(n) : 5;
  endfunction

endpackage

`default_nettype wire

/* hw/ctrl_msg_decoder.sv */
`default_nettype none

module ctrl_msg_decoder import sched_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int core_id_width = index_width(core_count),
  localparam int ret_width = core_id_width + slot_width
) (
  input  logic                     clk,
  input  logic                     rst,
  input  ctrl_word_t               ctrl_s_data,
  input  logic [core_id_width-1:0] ctrl_s_user,
  input  logic                     ctrl_s_valid,
  output logic                     ctrl_s_ready,
  output logic [ret_width-1:0]     ret,
  output logic                     ret_valid,
  input  logic                     ret_ready,
  output logic [core_id_width-1:0] load_core,
  output logic [slot_width-1:0]    load_count,
  output logic                     load_valid,
  input  logic                     load_ready
);

  typedef struct packed {
    logic [core_id_width-1:0] core;
    logic [slot_width-1:0]    slot;
  } slot_return_t;

  ctrl_msg_t msg;
  logic [slot_width-1:0] msg_slot;
  logic is_return, is_load, accept;
  slot_return_t ret_q;

  assign msg = ctrl_msg_t'(ctrl_s_data);
  assign msg_slot = msg.desc[slot_lsb +: slot_width];
  assign is_return = (msg.msg_type == msg_slot_return);
  assign is_load = (msg.msg_type == msg_slot_load);

  // other types are swallowed right away
  assign ctrl_s_ready = is_return ? !ret_valid : (is_load ? !load_valid : 1'b1);
  assign accept = ctrl_s_valid && ctrl_s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid <= 1'b0;
      load_valid <= 1'b0;
    end else begin
      if (ret_valid && ret_ready)
        ret_valid <= 1'b0;
      // a return of slot 0 carries nothing
      if (accept && is_return && (msg_slot != '0))
        ret_valid <= 1'b1;
      if (load_valid && load_ready)
        load_valid <= 1'b0;
      if (accept && is_load)
        load_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_return) begin
      ret_q.core <= ctrl_s_user;
      ret_q.slot <= msg_slot;
    end
    // the sending core loads its own pool
    if (accept && is_load) begin
      load_core <= ctrl_s_user;
      load_count <= msg_slot;
    end
  end

  assign ret = ret_q;

endmodule

`default_nettype wire

/* hw/slot_loader.sv */
`default_nettype none

module slot_loader import sched_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int core_id_width = index_width(core_count)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [core_id_width-1:0] load_core,
  input  logic [slot_width-1:0]    load_count,
  input  logic                     load_valid,
  output logic                     load_ready,
  output logic [core_count-1:0]    clear,
  output logic [core_count-1:0]    fill_valid,
  output logic [slot_width-1:0]    fill_slot
);

  typedef enum logic [1:0] {st_idle, st_clear, st_fill} state_e;

  state_e state_q;
  logic [core_id_width-1:0] core_q;
  logic [slot_width-1:0] last_q;
  logic [slot_width-1:0] slot_q;
  logic [slot_width-1:0] capped_count;

  // never load more slots than the pool holds
  assign capped_count = (load_count > slot_width'(slot_count)) ?
                        slot_width'(slot_count) : load_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (load_valid) begin
            core_q <= load_core;
            last_q <= capped_count;
            state_q <= st_clear;
          end
        end
        st_clear: begin
          slot_q <= slot_width'(1);
          state_q <= (last_q == '0) ? st_idle : st_fill;
        end
        st_fill: begin
          if (slot_q == last_q)
            state_q <= st_idle;
          else
            slot_q <= slot_q + 1'b1;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign load_ready = (state_q == st_idle);
  assign fill_slot = slot_q;

  always_comb begin
    clear = '0;
    fill_valid = '0;
    if (state_q == st_clear)
      clear[core_q] = 1'b1;
    if (state_q == st_fill)
      fill_valid[core_q] = 1'b1;
  end

endmodule

`default_nettype wire

/* hw/slot_pool.sv */
`default_nettype none

module slot_pool import sched_pkg::*; #(
  parameter int slot_count = 4,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int ptr_width = index_width(slot_count)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,
  input  logic                  push,
  input  logic [slot_width-1:0] push_slot,
  input  logic                  pop,
  output logic [slot_width-1:0] head,
  output logic                  head_valid,
  output logic [slot_width-1:0] count
);

  logic [slot_width-1:0] mem [slot_count];
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] wr_ptr;
  logic [slot_width-1:0] count_q;
  logic full;
  logic do_push;
  logic do_pop;

  // wrap for any depth, not only powers of two
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
    if (p == ptr_width'(slot_count - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign full = (count_q == slot_width'(slot_count));
  assign head_valid = (count_q != '0);
  // pushes into a full pool are lost
  assign do_push = push && !full && !clear;
  assign do_pop = pop && head_valid && !clear;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count_q <= '0;
    end else begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_slot;
  end

  assign head = mem[rd_ptr];
  assign count = count_q;

endmodule

`default_nettype wire

/* hw/core_selector.sv */
`default_nettype none

module core_selector import sched_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int core_id_width = index_width(core_count)
) (
  input  logic [core_count*slot_width-1:0] counts,
  output logic [core_id_width-1:0]         sel_core
);

  // tree padded up to a power of two, padding never wins
  localparam int levels = core_id_width;
  localparam int leaf_count = 1 << levels;

  logic [slot_width-1:0] lvl_val [levels+1][leaf_count];
  logic [core_id_width-1:0] lvl_idx [levels+1][leaf_count];

  always_comb begin
    for (int l = 0; l <= levels; l++) begin
      for (int i = 0; i < leaf_count; i++) begin
        lvl_val[l][i] = '0;
        lvl_idx[l][i] = '0;
      end
    end
    for (int i = 0; i < leaf_count; i++) begin
      if (i < core_count)
        lvl_val[0][i] = counts[i*slot_width +: slot_width];
      lvl_idx[0][i] = core_id_width'(i);
    end
    for (int l = 1; l <= levels; l++) begin
      for (int i = 0; i < leaf_count / 2; i++) begin
        if (i < (leaf_count >> l)) begin
          // strict compare keeps ties on the lower index
          if (lvl_val[l-1][2*i+1] > lvl_val[l-1][2*i]) begin
            lvl_val[l][i] = lvl_val[l-1][2*i+1];
            lvl_idx[l][i] = lvl_idx[l-1][2*i+1];
          end else begin
            lvl_val[l][i] = lvl_val[l-1][2*i];
            lvl_idx[l][i] = lvl_idx[l-1][2*i];
          end
        end
      end
    end
  end

  assign sel_core = lvl_idx[levels][0];

endmodule

`default_nettype wire

/* hw/port_dest_assigner.sv */
`default_nettype none

module port_dest_assigner import sched_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  parameter int interface_count = 2,
  parameter int data_width = 64,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int core_id_width = index_width(core_count),
  localparam int tag_width = tag_width_of(slot_count),
  localparam int id_tag_width = core_id_width + tag_width,
  localparam int keep_width = data_width / 8,
  localparam int if_width = index_width(interface_count)
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [interface_count*data_width-1:0]   rx_data,
  input  logic [interface_count*keep_width-1:0]   rx_keep,
  input  logic [interface_count-1:0]              rx_valid,
  output logic [interface_count-1:0]              rx_ready,
  input  logic [interface_count-1:0]              rx_last,
  output logic [interface_count*data_width-1:0]   core_data,
  output logic [interface_count*keep_width-1:0]   core_keep,
  output logic [interface_count*id_tag_width-1:0] core_dest,
  output logic [interface_count*if_width-1:0]     core_user,
  output logic [interface_count-1:0]              core_valid,
  input  logic [interface_count-1:0]              core_ready,
  output logic [interface_count-1:0]              core_last,
  input  logic [core_id_width-1:0]                sel_core,
  input  logic [slot_width-1:0]                   sel_slot,
  input  logic                                    any_slot,
  output logic [core_count-1:0]                   pop
);

  typedef struct packed {
    logic [core_id_width-1:0] core;
    logic [tag_width-1:0]     slot;
  } dest_t;

  dest_t dest_q [interface_count];
  logic [interface_count-1:0] dest_v;
  logic [interface_count-1:0] sending_last;
  logic [interface_count-1:0] req;
  logic [if_width-1:0] rr_q;
  logic [if_width-1:0] grant_idx;
  logic grant_valid;

  assign sending_last = rx_valid & rx_ready & rx_last;
  // no requests while every pool is empty
  assign req = (~dest_v | sending_last) & {interface_count{any_slot}};

  // first requester at or after the pointer
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx = '0;
    for (int k = 0; k < interface_count; k++) begin
      cand = int'(rr_q) + k;
      if (cand >= interface_count)
        cand = cand - interface_count;
      if (!grant_valid && req[cand]) begin
        grant_valid = 1'b1;
        grant_idx = if_width'(cand);
      end
    end
  end

  always_comb begin
    pop = '0;
    if (grant_valid)
      pop[sel_core] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_v <= '0;
      rr_q <= '0;
    end else begin
      dest_v <= dest_v & ~sending_last;
      if (grant_valid) begin
        dest_v[grant_idx] <= 1'b1;
        rr_q <= (grant_idx == if_width'(interface_count - 1)) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      dest_q[grant_idx].core <= sel_core;
      dest_q[grant_idx].slot <= tag_width'(sel_slot);
    end
  end

  // data path gated by a valid destination
  for (genvar i = 0; i < interface_count; i++) begin : g_if
    assign core_valid[i] = rx_valid[i] && dest_v[i];
    assign core_last[i] = rx_last[i] && dest_v[i];
    assign core_data[i*data_width +: data_width] =
      dest_v[i] ? rx_data[i*data_width +: data_width] : '0;
    assign core_keep[i*keep_width +: keep_width] =
      dest_v[i] ? rx_keep[i*keep_width +: keep_width] : '0;
    assign core_dest[i*id_tag_width +: id_tag_width] = dest_q[i];
    assign core_user[i*if_width +: if_width] = if_width'(i);
    assign rx_ready[i] = core_ready[i] && dest_v[i];
  end

endmodule

`default_nettype wire

/* hw/slot_scheduler.sv */
`default_nettype none

module slot_scheduler import sched_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  parameter int interface_count = 2,
  parameter int data_width = 64,
  localparam int slot_width = slot_width_of(slot_count),
  localparam int core_id_width = index_width(core_count),
  localparam int tag_width = tag_width_of(slot_count),
  localparam int id_tag_width = core_id_width + tag_width,
  localparam int keep_width = data_width / 8,
  localparam int if_width = index_width(interface_count)
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  ctrl_word_t                              ctrl_s_data,
  input  logic [core_id_width-1:0]                ctrl_s_user,
  input  logic                                    ctrl_s_valid,
  output logic                                    ctrl_s_ready,
  input  logic [interface_count*data_width-1:0]   rx_data,
  input  logic [interface_count*keep_width-1:0]   rx_keep,
  input  logic [interface_count-1:0]              rx_valid,
  output logic [interface_count-1:0]              rx_ready,
  input  logic [interface_count-1:0]              rx_last,
  output logic [interface_count*data_width-1:0]   core_data,
  output logic [interface_count*keep_width-1:0]   core_keep,
  output logic [interface_count*id_tag_width-1:0] core_dest,
  output logic [interface_count*if_width-1:0]     core_user,
  output logic [interface_count-1:0]              core_valid,
  input  logic [interface_count-1:0]              core_ready,
  output logic [interface_count-1:0]              core_last
);

  typedef struct packed {
    logic [core_id_width-1:0] core;
    logic [slot_width-1:0]    slot;
  } slot_return_t;

  slot_return_t ret;
  logic ret_valid, ret_ready;
  logic [core_id_width-1:0] load_core;
  logic [slot_width-1:0] load_count;
  logic load_valid, load_ready;
  logic [core_count-1:0] clear, fill_valid, pool_busy, pool_push, pool_pop, head_valid;
  logic [slot_width-1:0] fill_slot;
  logic [slot_width-1:0] pool_head [core_count];
  logic [core_count*slot_width-1:0] counts;
  logic [core_id_width-1:0] sel_core;

  ctrl_msg_decoder #(.core_count(core_count), .slot_count(slot_count)) u_decoder (
    .clk(clk), .rst(rst),
    .ctrl_s_data(ctrl_s_data), .ctrl_s_user(ctrl_s_user),
    .ctrl_s_valid(ctrl_s_valid), .ctrl_s_ready(ctrl_s_ready),
    .ret(ret), .ret_valid(ret_valid), .ret_ready(ret_ready),
    .load_core(load_core), .load_count(load_count),
    .load_valid(load_valid), .load_ready(load_ready)
  );

  slot_loader #(.core_count(core_count), .slot_count(slot_count)) u_loader (
    .clk(clk), .rst(rst),
    .load_core(load_core), .load_count(load_count),
    .load_valid(load_valid), .load_ready(load_ready),
    .clear(clear), .fill_valid(fill_valid), .fill_slot(fill_slot)
  );

  // returns wait while their core is being loaded
  assign pool_busy = clear | fill_valid;
  assign ret_ready = !pool_busy[ret.core];

  for (genvar c = 0; c < core_count; c++) begin : g_pool
    assign pool_push[c] = fill_valid[c] ||
                          (ret_valid && ret_ready && (ret.core == core_id_width'(c)));

    slot_pool #(.slot_count(slot_count)) u_pool (
      .clk(clk), .rst(rst),
      .clear(clear[c]),
      .push(pool_push[c]),
      .push_slot(fill_valid[c] ? fill_slot : ret.slot),
      .pop(pool_pop[c]),
      .head(pool_head[c]),
      .head_valid(head_valid[c]),
      .count(counts[c*slot_width +: slot_width])
    );
  end

  core_selector #(.core_count(core_count), .slot_count(slot_count)) u_selector (
    .counts(counts),
    .sel_core(sel_core)
  );

  port_dest_assigner #(
    .core_count(core_count),
    .slot_count(slot_count),
    .interface_count(interface_count),
    .data_width(data_width)
  ) u_assigner (
    .clk(clk), .rst(rst),
    .rx_data(rx_data), .rx_keep(rx_keep), .rx_valid(rx_valid),
    .rx_ready(rx_ready), .rx_last(rx_last),
    .core_data(core_data), .core_keep(core_keep), .core_dest(core_dest),
    .core_user(core_user), .core_valid(core_valid),
    .core_ready(core_ready), .core_last(core_last),
    .sel_core(sel_core),
    .sel_slot(pool_head[sel_core]),
    .any_slot(|head_valid),
    .pop(pool_pop)
  );

endmodule

`default_nettype wire

/* test/tb_slot_scheduler.sv */
`default_nettype none

module tb_slot_scheduler import sched_pkg::*; ();

  localparam int core_count = 4;
  localparam int slot_count = 4;
  localparam int interface_count = 2;
  localparam int data_width = 64;
  localparam int keep_width = data_width / 8;
  localparam int tag_width = 5;
  localparam int id_tag_width = 2 + tag_width;
  localparam int row_count = 27;
  localparam int clk_period = 100;

  localparam logic [1:0] row_ctrl = 2'd0;
  localparam logic [1:0] row_pkt = 2'd1;
  localparam logic [1:0] row_nodest = 2'd2;

  // each row holds a control message, a packet or an idle check
  typedef struct packed {
    logic [1:0] kind;
    logic [1:0] idx;
    logic [3:0] mtype;
    logic [3:0] val;
    logic [3:0] len;
    logic [3:0] stall;
    logic [1:0] exp_core;
    logic [2:0] exp_slot;
  } row_t;

  logic clk;
  logic rst;
  ctrl_word_t ctrl_s_data;
  logic [1:0] ctrl_s_user;
  logic ctrl_s_valid;
  logic ctrl_s_ready;
  logic [interface_count*data_width-1:0] rx_data, core_data;
  logic [interface_count*keep_width-1:0] rx_keep, core_keep;
  logic [interface_count-1:0] rx_valid, rx_ready, rx_last;
  logic [interface_count-1:0] core_valid, core_ready, core_last;
  logic [interface_count*id_tag_width-1:0] core_dest;
  logic [interface_count-1:0] core_user;

  row_t rows [row_count];
  int seed;

  // reference pools and destinations
  int pool_mem [core_count][slot_count];
  int pool_n [core_count];
  logic m_dv [interface_count];
  int m_core [interface_count];
  int m_slot [interface_count];
  int m_rr;

  slot_scheduler #(
    .core_count(core_count),
    .slot_count(slot_count),
    .interface_count(interface_count),
    .data_width(data_width)
  ) UUT (
    .clk(clk), .rst(rst),
    .ctrl_s_data(ctrl_s_data), .ctrl_s_user(ctrl_s_user),
    .ctrl_s_valid(ctrl_s_valid), .ctrl_s_ready(ctrl_s_ready),
    .rx_data(rx_data), .rx_keep(rx_keep), .rx_valid(rx_valid),
    .rx_ready(rx_ready), .rx_last(rx_last),
    .core_data(core_data), .core_keep(core_keep), .core_dest(core_dest),
    .core_user(core_user), .core_valid(core_valid),
    .core_ready(core_ready), .core_last(core_last)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(clk_period * 200 * row_count + clk_period * 10);
    $display("timeout, the table did not finish in time");
    $display("Testbench failed");
    $fatal(1);
  end

  task automatic expect_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s (time %0t)", what, $time);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic row_t ctrl_row(input int user, input int mtype, input int val);
    row_t r;
    r = '0;
    r.kind = row_ctrl;
    r.idx = 2'(user);
    r.mtype = 4'(mtype);
    r.val = 4'(val);
    return r;
  endfunction

  function automatic row_t pkt_row(input int iface, input int len, input int stall,
                                   input int core, input int slot);
    row_t r;
    r = '0;
    r.kind = row_pkt;
    r.idx = 2'(iface);
    r.len = 4'(len);
    r.stall = 4'(stall);
    r.exp_core = 2'(core);
    r.exp_slot = 3'(slot);
    return r;
  endfunction

  function automatic row_t nodest_row(input int iface);
    row_t r;
    r = '0;
    r.kind = row_nodest;
    r.idx = 2'(iface);
    return r;
  endfunction

  task automatic load_table();
    rows[0] = nodest_row(0);
    rows[1] = ctrl_row(2, 3, 3);
    // core 2 hands out slots 1, 2, 3 in order
    rows[2] = pkt_row(0, 3, 0, 2, 1);
    rows[3] = pkt_row(1, 2, 0, 2, 2);
    rows[4] = pkt_row(0, 1, 0, 2, 3);
    rows[5] = nodest_row(1);
    rows[6] = ctrl_row(0, 3, 2);
    rows[7] = ctrl_row(1, 3, 3);
    rows[8] = ctrl_row(3, 3, 3);
    rows[9] = ctrl_row(2, 3, 2);
    rows[10] = pkt_row(0, 2, 0, 0, 2);
    rows[11] = pkt_row(1, 2, 0, 0, 1);
    rows[12] = pkt_row(0, 3, 0, 1, 1);
    rows[13] = pkt_row(1, 1, 0, 3, 1);
    // returns followed by ignored messages
    rows[14] = ctrl_row(0, 0, 3);
    rows[15] = ctrl_row(0, 0, 0);
    rows[16] = ctrl_row(0, 1, 2);
    rows[17] = ctrl_row(1, 2, 1);
    rows[18] = ctrl_row(0, 0, 4);
    rows[19] = pkt_row(0, 2, 1, 1, 2);
    rows[20] = pkt_row(1, 4, 2, 2, 1);
    rows[21] = pkt_row(0, 1, 0, 0, 3);
    rows[22] = pkt_row(1, 2, 0, 3, 2);
    rows[23] = pkt_row(0, 2, 0, 0, 4);
    rows[24] = pkt_row(1, 1, 0, 1, 3);
    rows[25] = pkt_row(0, 3, 0, 2, 2);
    rows[26] = nodest_row(0);
  endtask

  // most free slots with ties to the lowest index
  function automatic int pick_fullest_core();
    int best;
    best = 0;
    for (int c = 1; c < core_count; c++)
      if (pool_n[c] > pool_n[best])
        best = c;
    return best;
  endfunction

  task automatic model_grant();
    int i;
    int c;
    int total;
    int cand;
    for (int n = 0; n < interface_count; n++) begin
      total = 0;
      for (int k = 0; k < core_count; k++)
        total += pool_n[k];
      i = -1;
      for (int k = 0; k < interface_count; k++) begin
        cand = (m_rr + k) % interface_count;
        if (i < 0 && !m_dv[cand])
          i = cand;
      end
      if (i >= 0 && total > 0) begin
        c = pick_fullest_core();
        m_dv[i] = 1'b1;
        m_core[i] = c;
        m_slot[i] = pool_mem[c][0];
        for (int k = 0; k < slot_count - 1; k++)
          pool_mem[c][k] = pool_mem[c][k+1];
        pool_n[c]--;
        m_rr = (i + 1) % interface_count;
      end
    end
  endtask

  task automatic send_ctrl(input row_t r);
    ctrl_msg_t msg;
    int c;
    int v;
    logic held;
    c = int'(r.idx);
    v = int'(r.val);
    msg.msg_type = msg_type_e'(r.mtype);
    msg.desc = '0;
    msg.desc[slot_lsb +: 4] = r.val;
    held = (msg.msg_type == msg_slot_load) ||
           (msg.msg_type == msg_slot_return && v != 0);
    ctrl_s_data = ctrl_word_t'(msg);
    ctrl_s_user = r.idx;
    ctrl_s_valid = 1'b1;
    #(clk_period / 4);
    while (!ctrl_s_ready) begin
      @(negedge clk);
      #(clk_period / 4);
    end
    @(negedge clk);
    ctrl_s_valid = 1'b0;
    #(clk_period / 4);
    // a held load or return blocks its type for one cycle
    expect_equal("ctrl_s_ready after accept", 64'(ctrl_s_ready), 64'(!held));
    if (msg.msg_type == msg_slot_load) begin
      pool_n[c] = (v > slot_count) ? slot_count : v;
      for (int k = 0; k < slot_count; k++)
        pool_mem[c][k] = k + 1;
    end else if (msg.msg_type == msg_slot_return && v != 0 && pool_n[c] < slot_count) begin
      pool_mem[c][pool_n[c]] = v;
      pool_n[c]++;
    end
    model_grant();
    repeat (8) @(negedge clk);
  endtask

  task automatic send_packet(input row_t r);
    int i;
    int len;
    logic [data_width-1:0] word;
    logic [keep_width-1:0] keep;
    logic [id_tag_width-1:0] exp_dest;
    i = int'(r.idx);
    len = int'(r.len);
    exp_dest = {r.exp_core, tag_width'(r.exp_slot)};
    expect_true(m_dv[i] && m_core[i] == int'(r.exp_core) && m_slot[i] == int'(r.exp_slot),
                "reference model and table disagree on a packet destination");
    for (int w = 0; w < len; w++) begin
      word = {$random(seed), $random(seed)};
      keep = (w == len - 1) ? (8'hff >> (w % 4)) : 8'hff;
      rx_data[i*data_width +: data_width] = word;
      rx_keep[i*keep_width +: keep_width] = keep;
      rx_last[i] = (w == len - 1);
      rx_valid[i] = 1'b1;
      if (r.stall != 0 && w == int'(r.stall)) begin
        core_ready[i] = 1'b0;
        repeat (3) begin
          #(clk_period / 4);
          expect_equal("rx_ready while stalled", 64'(rx_ready[i]), 64'd0);
          expect_equal("core_valid while stalled", 64'(core_valid[i]), 64'd1);
          expect_equal("core_dest while stalled",
                       64'(core_dest[i*id_tag_width +: id_tag_width]), 64'(exp_dest));
          @(negedge clk);
        end
        core_ready[i] = 1'b1;
      end
      #(clk_period / 4);
      while (!rx_ready[i]) begin
        @(negedge clk);
        #(clk_period / 4);
      end
      expect_equal("core_valid", 64'(core_valid[i]), 64'd1);
      expect_equal("core_data", core_data[i*data_width +: data_width], word);
      expect_equal("core_keep", 64'(core_keep[i*keep_width +: keep_width]), 64'(keep));
      expect_equal("core_last", 64'(core_last[i]), 64'(w == len - 1));
      expect_equal("core_dest", 64'(core_dest[i*id_tag_width +: id_tag_width]),
                   64'(exp_dest));
      expect_equal("core_user", 64'(core_user[i]), 64'(i));
      @(negedge clk);
    end
    rx_valid[i] = 1'b0;
    rx_last[i] = 1'b0;
    // last word frees the destination
    m_dv[i] = 1'b0;
    model_grant();
    repeat (2) @(negedge clk);
  endtask

  task automatic check_no_dest(input row_t r);
    int i;
    i = int'(r.idx);
    expect_true(!m_dv[i], "reference model holds a destination on an idle check row");
    rx_data[i*data_width +: data_width] = {$random(seed), $random(seed)};
    rx_keep[i*keep_width +: keep_width] = '1;
    rx_valid[i] = 1'b1;
    repeat (3) begin
      #(clk_period / 4);
      expect_equal("rx_ready without destination", 64'(rx_ready[i]), 64'd0);
      expect_equal("core_valid without destination", 64'(core_valid[i]), 64'd0);
      @(negedge clk);
    end
    rx_valid[i] = 1'b0;
  endtask

  initial begin
    seed = 46032;
    rst = 1'b1;
    ctrl_s_data = '0;
    ctrl_s_user = '0;
    ctrl_s_valid = 1'b0;
    rx_data = '0;
    rx_keep = '0;
    rx_valid = '0;
    rx_last = '0;
    core_ready = '1;
    m_rr = 0;
    for (int c = 0; c < core_count; c++)
      pool_n[c] = 0;
    for (int i = 0; i < interface_count; i++) begin
      m_dv[i] = 1'b0;
      m_core[i] = 0;
      m_slot[i] = 0;
    end
    load_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int n = 0; n < row_count; n++) begin
      case (rows[n].kind)
        row_ctrl: send_ctrl(rows[n]);
        row_pkt: send_packet(rows[n]);
        default: check_no_dest(rows[n]);
      endcase
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/sched_pkg.sv
hw/ctrl_msg_decoder.sv
hw/slot_loader.sv
hw/slot_pool.sv
hw/core_selector.sv
hw/port_dest_assigner.sv
hw/slot_scheduler.sv
test/tb_slot_scheduler.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_slot_scheduler \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_slot_scheduler > sim.log 2>&1 || true
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
